/* compile.f */
+incdir+include
design/display_pkg.sv
design/game_pkg.sv
design/vga_timing.sv
design/obstacle_field.sv
design/score_counter.sv
design/game_control.sv
design/pixel_painter.sv
design/game_top.sv
tb/game_top_tb.sv

/* tb/game_stim.txt */
// Columns: op address data expect, all hex. Ops: 1 write, 2 read and compare, 3 wait data ticks,
// 4 motion (x = expect - score), 5 hit (runner x = x - data), 6 save, 7 same, 8 range data..expect
// Reset state
2 003 00000000 00000002
2 004 00000000 00000000
2 008 00000000 000004B0
2 009 00000000 00000640
2 00A 00000000 00000708
2 00B 00000000 00000578
// Runner lifted clear, obstacles move one pixel per tick
1 001 00000000 00000000
3 000 00000014 00000000
4 008 00000000 000004B0
4 009 00000000 00000640
4 00A 00000000 00000708
4 00B 00000000 00000578
// Runner dropped just left of the cactus
5 008 0000000A 00000000
1 001 000000F8 00000000
3 000 00000001 00000000
2 003 00000000 00000003
6 004 00000000 00000000
6 008 00000000 00000000
6 00B 00000000 00000000
3 000 00000005 00000000
7 004 00000000 00000000
7 008 00000000 00000000
7 00B 00000000 00000000
// Replay with the runner lifted out of the way
1 001 00000000 00000000
1 002 00000001 00000000
2 003 00000000 00000002
7 004 00000000 00000000
2 008 00000000 000004B0
2 009 00000000 00000640
2 00A 00000000 00000708
2 00B 00000000 00000578
// Cactus wraps at the 1200th tick, check about 10 ticks later
3 000 000004BA 00000000
8 008 000004F1 000008FF
2 003 00000000 00000002
0 000 00000000 00000000

/* tb/game_top_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the game core: stimulus reader, bus tasks,
// hsync and VGA output monitor, watchdog and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module game_top_tb;
    import game_pkg::*;
    import display_pkg::*;

    localparam int TICK_CYCLES  = 64;
    localparam int CLK_PERIOD   = 20;
    localparam int MAX_LINES    = 64;
    localparam int HS_PERIOD    = 1600;
    localparam int HS_WIDTH     = 192;
    localparam int FRAME_CYCLES = 1600 * 525;

    // Stimulus operations
    localparam int OP_END    = 0;
    localparam int OP_WRITE  = 1;
    localparam int OP_READ   = 2;
    localparam int OP_WAIT   = 3;
    localparam int OP_MOTION = 4;
    localparam int OP_HIT    = 5;
    localparam int OP_SAVE   = 6;
    localparam int OP_SAME   = 7;
    localparam int OP_RANGE  = 8;

    logic        clk = 1'b0;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic        read;
    logic [8:0]  address;
    logic [31:0] writedata;
    logic [31:0] readdata;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;

    logic [31:0] stim [4*MAX_LINES];
    logic [31:0] saved [16];
    int          errors;
    int          hs_checks;
    longint      total_ticks;
    bit          stim_loaded = 1'b0;

    // hsync monitor state
    longint      cycle = 0;
    longint      fall_at;
    logic        hs_prev;
    bit          have_fall;

    game_top #(.TICK_CYCLES(TICK_CYCLES)) u_game_top (
        .clk, .reset, .chipselect, .write, .read, .address, .writedata, .readdata,
        .vga_r, .vga_g, .vga_b, .vga_clk, .vga_hs, .vga_vs, .vga_blank_n, .vga_sync_n
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic write_reg(input logic [8:0] addr, input logic [31:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= data;
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
    endtask

    // Data is registered on the edge that sees the request
    task automatic read_reg(input logic [8:0] addr, output logic [31:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        read       <= 1'b1;
        address    <= addr;
        @(posedge clk);
        chipselect <= 1'b0;
        read       <= 1'b0;
        @(negedge clk);
        data = readdata;
    endtask

    task automatic wait_ticks(input int n);
        repeat (n * TICK_CYCLES) @(posedge clk);
    endtask

    function automatic int bcd_to_int(input logic [31:0] raw);
        int value;
        value = 0;
        for (int i = 4; i >= 0; i--)
            value = value * 10 + int'(raw[4*i +: 4]);
        return value;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // Score read on both sides so a tick in between forces a retry
    task automatic check_motion(input logic [8:0] addr, input logic [31:0] start_x);
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] x;
        bit          done;
        done = 1'b0;
        for (int tries = 0; tries < 4 && !done; tries++) begin
            read_reg(REG_SCORE, s1);
            read_reg(addr, x);
            read_reg(REG_SCORE, s2);
            if (s1 == s2) begin
                done = 1'b1;
                check_value(x, start_x - bcd_to_int(s1),
                            $sformatf("obstacle x at 0x%0h", addr));
            end
        end
        assert (done) else begin
            errors++;
            $display("The score kept changing while reading obstacle 0x%0h", addr);
        end
    endtask

    // Expected VGA outputs with the counters p cycles past reset
    task automatic check_outputs(input longint p);
        longint h;
        longint v;
        longint row;
        h   = p % H_TOTAL;
        v   = (p / H_TOTAL) % V_TOTAL;
        // Colour output is one pixel behind the counters
        row = ((p - 1) / H_TOTAL) % V_TOTAL;
        check_value(32'(vga_blank_n), 32'(h < H_ACTIVE && v < V_ACTIVE), "vga_blank_n");
        check_value(32'(vga_vs),
                    32'(!(v >= V_ACTIVE + V_FRONT && v < V_ACTIVE + V_FRONT + V_SYNC)),
                    "vga_vs");
        check_value(32'(vga_clk), 32'(h % 2), "vga_clk");
        check_value(32'(vga_sync_n), 32'd0, "vga_sync_n");
        // No box reaches the rows between the lifted runner and the pterodactyl
        if (row >= 32 && row < 200)
            check_value({8'd0, vga_r, vga_g, vga_b}, 32'(SKY_RGB), "pixel colour");
    endtask

    always @(negedge clk) begin
        if (reset) begin
            hs_prev   = 1'b1;
            have_fall = 1'b0;
        end else begin
            cycle++;
            check_outputs(cycle - 1);
            if (hs_prev && !vga_hs) begin
                if (have_fall)
                    assert (cycle - fall_at == HS_PERIOD) else begin
                        errors++;
                        $display("ERR %0t: hsync period %0d cycles, expected %0d",
                                 $time, cycle - fall_at, HS_PERIOD);
                    end
                fall_at   = cycle;
                have_fall = 1'b1;
            end
            if (!hs_prev && vga_hs && have_fall) begin
                assert (cycle - fall_at == HS_WIDTH) else begin
                    errors++;
                    $display("ERR %0t: hsync low for %0d cycles, expected %0d",
                             $time, cycle - fall_at, HS_WIDTH);
                end
                hs_checks++;
            end
            hs_prev = vga_hs;
        end
    end

    initial begin
        longint limit_ns;
        wait (stim_loaded);
        limit_ns = (total_ticks + 100) * TICK_CYCLES * CLK_PERIOD
                   + 2 * FRAME_CYCLES * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expect_val;
        logic [31:0] got;
        int          idx;
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        read       = 1'b0;
        address    = '0;
        writedata  = '0;
        errors     = 0;
        hs_checks  = 0;
        foreach (stim[i])
            stim[i] = '0;
        $readmemh("tb/game_stim.txt", stim);
        total_ticks = 0;
        for (int i = 0; i < MAX_LINES; i++)
            if (stim[4*i] == OP_WAIT)
                total_ticks += stim[4*i+2];
        stim_loaded = 1'b1;

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        idx = 0;
        while (idx < MAX_LINES && stim[4*idx] != OP_END) begin
            op         = stim[4*idx];
            addr       = stim[4*idx+1];
            data       = stim[4*idx+2];
            expect_val = stim[4*idx+3];
            case (op)
                OP_WRITE:  write_reg(addr[8:0], data);
                OP_WAIT:   wait_ticks(data);
                OP_MOTION: check_motion(addr[8:0], expect_val);
                OP_SAVE:   read_reg(addr[8:0], saved[addr[3:0]]);
                OP_READ: begin
                    read_reg(addr[8:0], got);
                    check_value(got, expect_val, $sformatf("register 0x%0h", addr));
                end
                OP_HIT: begin
                    read_reg(addr[8:0], got);
                    write_reg(REG_RUNNER_X, got - data);
                end
                OP_SAME: begin
                    read_reg(addr[8:0], got);
                    check_value(got, saved[addr[3:0]], $sformatf("held register 0x%0h", addr));
                end
                OP_RANGE: begin
                    read_reg(addr[8:0], got);
                    assert (got >= data && got <= expect_val) else begin
                        errors++;
                        $display("ERR %0t: register 0x%0h read %0d, outside %0d to %0d",
                                 $time, addr, got, data, expect_val);
                    end
                end
                default: begin
                    errors++;
                    $display("Unknown operation %0d on stimulus line %0d", op, idx);
                end
            endcase
            idx++;
        end

        assert (idx > 0) else begin
            errors++;
            $display("No stimulus lines were read from the stimulus file");
        end
        assert (hs_checks > 0) else begin
            errors++;
            $display("No complete hsync pulse was seen during the run");
        end
        $display("Errors: %0d, hsync pulses checked: %0d", errors, hs_checks);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* design/game_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runner game core with register bus and VGA output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module game_top #(
    parameter int TICK_CYCLES = 2_000_000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                chipselect,
    input  logic                write,
    input  logic                read,
    input  game_pkg::reg_addr_t address,
    input  logic [31:0]         writedata,
    output logic [31:0]         readdata,
    output logic [7:0]          vga_r,
    output logic [7:0]          vga_g,
    output logic [7:0]          vga_b,
    output logic                vga_clk,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_blank_n,
    output logic                vga_sync_n
);
    import display_pkg::*;
    import game_pkg::*;

    hcount_t    hcount;
    vcount_t    vcount;
    obst_set_t  obst;
    obst_box_t  runner;
    bcd_t       score;
    rgb_t       rgb;
    logic [3:0] speed;
    logic       tick;
    logic       running;
    logic       replay;
    logic       game_over;

    vga_timing u_vga_timing (
        .clk, .reset, .hcount, .vcount, .vga_hs, .vga_vs,
        .vga_blank_n, .vga_sync_n, .vga_clk
    );

    obstacle_field #(.TICK_CYCLES(TICK_CYCLES)) u_obstacle_field (
        .clk, .reset, .running, .replay, .tick, .speed, .obst
    );

    score_counter u_score_counter (.clk, .reset, .tick, .score);

    game_control u_game_control (
        .clk, .reset, .chipselect, .write, .read, .address, .writedata, .readdata,
        .obst, .score, .speed, .runner, .running, .replay, .game_over
    );

    pixel_painter u_pixel_painter (
        .clk, .reset, .hcount, .vcount, .obst, .runner, .score, .game_over, .rgb
    );

    assign vga_r = rgb.r;
    assign vga_g = rgb.g;
    assign vga_b = rgb.b;

endmodule

`default_nettype wire

/* design/pixel_painter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-pixel colour: background, boxes, score digits, replay banner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module pixel_painter (
    input  logic                 clk,
    input  logic                 reset,
    input  display_pkg::hcount_t hcount,
    input  display_pkg::vcount_t vcount,
    input  game_pkg::obst_set_t  obst,
    input  game_pkg::obst_box_t  runner,
    input  game_pkg::bcd_t       score,
    input  logic                 game_over,
    output display_pkg::rgb_t    rgb
);
    import display_pkg::*;
    import game_pkg::*;

    `include "digit_font.svh"

    rgb_t       colour;
    hcount_t    rx;
    vcount_t    ry;
    logic [2:0] slot;
    logic [3:0] digit;
    logic       in_score;
    logic       in_banner;

    function automatic logic in_box(hcount_t px, vcount_t py, obst_box_t box);
        return (12'(px) >= 12'(box.x)) && (12'(px) <= 12'(box.x) + 12'(box.w)) &&
               (12'(py) >= 12'(box.y)) && (12'(py) <= 12'(box.y) + 12'(box.h));
    endfunction

    // Digits sit in 16 pixel slots, glyph in the left half
    assign rx    = hcount - hcount_t'(SCORE_X);
    assign ry    = vcount - vcount_t'(SCORE_Y);
    assign slot  = rx[6:4];
    assign digit = (slot < N_DIGITS) ? score[3'(N_DIGITS - 1) - slot] : 4'd0;

    assign in_score = !game_over && !rx[3] &&
                      (hcount >= SCORE_X) && (hcount < SCORE_X + 16 * N_DIGITS) &&
                      (vcount >= SCORE_Y) && (vcount < SCORE_Y + 8);

    assign in_banner = game_over &&
                       (hcount >= BANNER_X) && (hcount < BANNER_X + BANNER_W) &&
                       (vcount >= BANNER_Y) && (vcount < BANNER_Y + BANNER_H);

    always_comb begin
        if (vcount < GROUND_Y)
            colour = SKY_RGB;
        else if (vcount == GROUND_Y)
            colour = LINE_RGB;
        else
            colour = GROUND_RGB;

        for (int i = 0; i < N_OBST; i++)
            if (in_box(hcount, vcount, obst[i]))
                colour = OBSTACLE_RGB;
        // Runner is drawn on top of the obstacles
        if (in_box(hcount, vcount, runner))
            colour = RUNNER_RGB;

        if (in_score && DIGIT_FONT[digit][ry[2:0]][3'd7 - rx[2:0]])
            colour = DIGIT_RGB;
        if (in_banner)
            colour = BANNER_RGB;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            rgb <= '0;
        else
            rgb <= colour;
    end

endmodule

`default_nettype wire

/* design/game_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register bus, runner position, collision and game-over state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module game_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                chipselect,
    input  logic                write,
    input  logic                read,
    input  game_pkg::reg_addr_t address,
    input  game_pkg::bus_word_u writedata,
    output game_pkg::bus_word_u readdata,
    input  game_pkg::obst_set_t obst,
    input  game_pkg::bcd_t      score,
    input  logic [3:0]          speed,
    output game_pkg::obst_box_t runner,
    output logic                running,
    output logic                replay,
    output logic                game_over
);
    import game_pkg::*;

    coord_t    runner_x;
    coord_t    runner_y;
    logic      wr_en;
    logic      hit;
    bus_word_u rd_next;

    // Boxes span x to x + w inclusive
    function automatic logic boxes_overlap(obst_box_t a, obst_box_t b);
        return (12'(a.x) <= 12'(b.x) + 12'(b.w)) && (12'(b.x) <= 12'(a.x) + 12'(a.w)) &&
               (12'(a.y) <= 12'(b.y) + 12'(b.h)) && (12'(b.y) <= 12'(a.y) + 12'(a.h));
    endfunction

    assign wr_en   = chipselect && write;
    assign running = !game_over;
    assign runner  = '{x: runner_x, y: runner_y,
                       w: 6'(RUNNER_W - 1), h: 6'(RUNNER_H - 1)};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            runner_x <= RUNNER_START_X;
            runner_y <= RUNNER_START_Y;
            replay   <= 1'b0;
        end else begin
            replay <= wr_en && (address == REG_REPLAY) && writedata.ctrl.replay;
            if (wr_en && address == REG_RUNNER_X)
                runner_x <= writedata.pos.coord;
            if (wr_en && address == REG_RUNNER_Y)
                runner_y <= writedata.pos.coord;
        end
    end

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < N_OBST; i++)
            hit = hit | boxes_overlap(runner, obst[i]);
    end

    // Replay wins over a hit on the same edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            game_over <= 1'b0;
        else if (replay)
            game_over <= 1'b0;
        else if (hit)
            game_over <= 1'b1;
    end

    always_comb begin
        rd_next = '0;
        case (address)
            REG_RUNNER_X: rd_next.pos.coord = runner_x;
            REG_RUNNER_Y: rd_next.pos.coord = runner_y;
            REG_STATUS:   rd_next.raw       = 32'({speed, game_over});
            REG_SCORE:    rd_next.raw       = 32'(score);
            REG_OBST_X0, REG_OBST_X1, REG_OBST_X2, REG_OBST_X3:
                rd_next.pos.coord = obst[address[1:0]].x;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            readdata <= '0;
        else if (chipselect && read)
            readdata <= rd_next;
    end

endmodule

`default_nettype wire

/* design/score_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Five-digit BCD score, one count per motion tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module score_counter (
    input  logic           clk,
    input  logic           reset,
    input  logic           tick,
    output game_pkg::bcd_t score
);
    import game_pkg::*;

    bcd_t score_next;

    // Carry ripples up from the units digit, 99999 rolls over to 0
    always_comb begin
        logic carry;
        carry = 1'b1;
        for (int i = 0; i < N_DIGITS; i++) begin
            score_next[i] = score[i];
            if (carry) begin
                if (score[i] == 4'd9) begin
                    score_next[i] = 4'd0;
                end else begin
                    score_next[i] = score[i] + 4'd1;
                    carry         = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            score <= '0;
        else if (tick)
            score <= score_next;
    end

endmodule

`default_nettype wire

/* design/obstacle_field.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Motion tick, respawn LFSR, obstacle motion and speed-up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module obstacle_field #(
    parameter int TICK_CYCLES = 2_000_000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                running,
    input  logic                replay,
    output logic                tick,
    output logic [3:0]          speed,
    output game_pkg::obst_set_t obst
);
    import game_pkg::*;
    import display_pkg::*;

    logic [$clog2(TICK_CYCLES)-1:0] tick_cnt;
    logic              step;
    logic [5:0]        lfsr;
    logic [4:0]        pass_cnt;
    logic [4:0]        pass_next;
    logic [N_OBST-1:0] wrap;
    coord_t            respawn [N_OBST];

    // All obstacles at their start positions
    function automatic obst_set_t start_set();
        obst_set_t boxes;
        for (int i = 0; i < N_OBST; i++)
            boxes[i] = '{x: START_X[i], y: START_Y[i],
                         w: 6'(OBST_W[i] - 1), h: 6'(OBST_H[i] - 1)};
        return boxes;
    endfunction

    assign step = running && (tick_cnt == TICK_CYCLES - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= step;
            if (replay || step)
                tick_cnt <= '0;
            else if (running)
                tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // x^6 + x^5 + 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            lfsr <= LFSR_SEED;
        else if (step)
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
    end

    // Each obstacle takes its own slice of the LFSR
    always_comb begin
        respawn[OBST_CACTUS] = coord_t'(H_ACTIVE) + {lfsr, 3'd0};
        respawn[OBST_GROUP]  = coord_t'(H_ACTIVE) + {~lfsr, 3'd0};
        respawn[OBST_LAVA]   = coord_t'(H_ACTIVE) + {lfsr[3:0], 5'd0};
        respawn[OBST_PTERO]  = coord_t'(H_ACTIVE) + {lfsr[5:2], 5'd0};
    end

    always_comb begin
        pass_next = pass_cnt;
        for (int i = 0; i < N_OBST; i++) begin
            wrap[i]   = (obst[i].x <= coord_t'(speed));
            pass_next = pass_next + 5'(wrap[i]);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            obst     <= start_set();
            speed    <= 4'd1;
            pass_cnt <= '0;
        end else if (replay) begin
            obst     <= start_set();
            speed    <= 4'd1;
            pass_cnt <= '0;
        end else if (step) begin
            for (int i = 0; i < N_OBST; i++)
                obst[i].x <= wrap[i] ? respawn[i] : obst[i].x - coord_t'(speed);
            if (pass_next > PASSES_PER_STEP) begin
                pass_cnt <= '0;
                // Saturate instead of wrapping back to a crawl
                if (speed != 4'hF)
                    speed <= speed + 4'd1;
            end else begin
                pass_cnt <= pass_next;
            end
        end
    end

endmodule

`default_nettype wire

/* design/vga_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VGA pixel and line counters with sync and blank decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
    input  logic                 clk,
    input  logic                 reset,
    output display_pkg::hcount_t hcount,
    output display_pkg::vcount_t vcount,
    output logic                 vga_hs,
    output logic                 vga_vs,
    output logic                 vga_blank_n,
    output logic                 vga_sync_n,
    output logic                 vga_clk
);
    import display_pkg::*;

    logic end_of_line;
    logic end_of_field;

    assign end_of_line  = (hcount == hcount_t'(H_TOTAL - 1));
    assign end_of_field = (vcount == vcount_t'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            vcount <= end_of_field ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Sync pulses are active low
    assign vga_hs = !((hcount >= H_ACTIVE + H_FRONT) &&
                      (hcount <  H_ACTIVE + H_FRONT + H_SYNC));
    assign vga_vs = !((vcount >= V_ACTIVE + V_FRONT) &&
                      (vcount <  V_ACTIVE + V_FRONT + V_SYNC));

    assign vga_blank_n = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
    assign vga_sync_n  = 1'b0;
    assign vga_clk     = hcount[0];

endmodule

`default_nettype wire

/* design/game_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game objects, start positions, score type and register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package game_pkg;

    typedef logic [10:0] coord_t;

    localparam int N_OBST = 4;

    typedef enum logic [1:0] {
        OBST_CACTUS,
        OBST_GROUP,
        OBST_LAVA,
        OBST_PTERO
    } obst_id_e;

    // w and h hold the size minus one so that a 64 pixel box fits
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [5:0] w;
        logic [5:0] h;
    } obst_box_t;

    typedef obst_box_t [N_OBST-1:0] obst_set_t;

    // Tables in obst_id_e order
    localparam coord_t START_X [N_OBST] = '{11'd1200, 11'd1600, 11'd1800, 11'd1400};
    localparam coord_t START_Y [N_OBST] = '{11'd248, 11'd248, 11'd248, 11'd200};
    localparam int     OBST_W  [N_OBST] = '{32, 64, 32, 32};
    localparam int     OBST_H  [N_OBST] = '{32, 32, 32, 32};

    localparam int     RUNNER_W       = 32;
    localparam int     RUNNER_H       = 32;
    localparam coord_t RUNNER_START_X = 11'd100;
    localparam coord_t RUNNER_START_Y = 11'd248;

    localparam int PASSES_PER_STEP = 12;

    localparam int N_DIGITS = 5;
    typedef logic [N_DIGITS-1:0][3:0] bcd_t;

    localparam logic [5:0] LFSR_SEED = 6'b101011;

    typedef logic [8:0] reg_addr_t;

    localparam reg_addr_t REG_RUNNER_X = 9'd0;
    localparam reg_addr_t REG_RUNNER_Y = 9'd1;
    localparam reg_addr_t REG_REPLAY   = 9'd2;
    localparam reg_addr_t REG_STATUS   = 9'd3;
    localparam reg_addr_t REG_SCORE    = 9'd4;
    localparam reg_addr_t REG_OBST_X0  = 9'd8;
    localparam reg_addr_t REG_OBST_X1  = 9'd9;
    localparam reg_addr_t REG_OBST_X2  = 9'd10;
    localparam reg_addr_t REG_OBST_X3  = 9'd11;

    typedef struct packed {
        logic [20:0] unused;
        coord_t      coord;
    } pos_word_t;

    typedef struct packed {
        logic [30:0] unused;
        logic        replay;
    } ctrl_word_t;

    // One bus word, read as a position or as a control request
    typedef union packed {
        pos_word_t   pos;
        ctrl_word_t  ctrl;
        logic [31:0] raw;
    } bus_word_u;

endpackage

`default_nettype wire

/* design/display_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VGA timing, pixel colour type, palette and screen layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package display_pkg;

    // 1280 wide line, pixel clock at half the system clock
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 32;
    localparam int H_SYNC   = 192;
    localparam int H_BACK   = 96;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    localparam rgb_t SKY_RGB      = '{r: 8'd135, g: 8'd206, b: 8'd235};
    localparam rgb_t GROUND_RGB   = '{r: 8'd139, g: 8'd69,  b: 8'd19};
    localparam rgb_t LINE_RGB     = '{r: 8'd0,   g: 8'd0,   b: 8'd0};
    localparam rgb_t DIGIT_RGB    = '{r: 8'd0,   g: 8'd0,   b: 8'd0};
    localparam rgb_t OBSTACLE_RGB = '{r: 8'd34,  g: 8'd139, b: 8'd34};
    localparam rgb_t RUNNER_RGB   = '{r: 8'd83,  g: 8'd83,  b: 8'd83};
    localparam rgb_t BANNER_RGB   = '{r: 8'd200, g: 8'd40,  b: 8'd40};

    localparam int GROUND_Y = 280;
    localparam int SCORE_X  = 120;
    localparam int SCORE_Y  = 10;

    // Replay banner, centred above the ground
    localparam int BANNER_X = 560;
    localparam int BANNER_Y = 200;
    localparam int BANNER_W = 160;
    localparam int BANNER_H = 32;

endpackage

`default_nettype wire

/* include/digit_font.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8x8 glyph rows for the digits 0 to 9, bit 7 is the leftmost pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DIGIT_FONT_SVH
`define DIGIT_FONT_SVH

localparam logic [7:0] DIGIT_FONT [10][8] = '{
    '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
    '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
    '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
    '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
    '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
    '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
    '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
    '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
};

`endif
